// ==== compile.f ====
+incdir+logic
logic/router_pkg.sv
logic/route_ctrl.sv
logic/net_queue.sv
logic/wave_grid.sv
logic/path_tracer.sv
logic/tile_store.sv
logic/router_top.sv
test/tb_router.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the router testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -j 0 \
	-f compile.f --top-module tb_router -o sim_router

./obj_dir/sim_router | tee sim.log

if grep -q "Checks failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi

echo "simulation passed"
exit 0

// ==== test/router_trace.txt ====
// router trace, all words hex; first word is the number of cases
// per case: net count, GRID_DIM lines <map row> <weight row> from row 0,
// one line per net <id> <src x> <src y> <snk x> <snk y>,
// GRID_DIM expected rows from row 0, then the expected cost
2

// case 1: net 1 detours below a wall at x=3
1
0000F000 43214321
0010F010 14321432
0000F000 21432143
0000F000 32143214
00000000 43214321
00000000 14321432
00000000 21432143
00000000 32143214
1 1 1 5 1
0000F000
0010F110
0010F100
0010F100
00111100
00000000
00000000
00000000
19

// case 2: net 3 goes around the row taken by net 2
2
00003000 43214321
00000000 14321432
00000000 21432143
02000020 32143214
00000000 43214321
00000000 14321432
00003000 21432143
00000000 32143214
2 1 3 6 3
3 3 0 3 6
00003333
00000003
00000003
02222223
00003333
00003000
00003000
00000000
29

// ==== test/tb_router.sv ====
`timescale 1ns/1ns
`include "router_config.svh"

module tb_router;

	localparam int TRACE_WORDS = 256;
	localparam int WAIT_LIMIT = 500;

	logic clk;
	logic rst_n;
	logic map_valid;
	logic net_valid;
	router_pkg::map_row_t map_row;
	router_pkg::map_row_t weight_row;
	router_pkg::net_id_t net_id;
	router_pkg::point_t loc;
	logic busy;
	logic out_valid;
	router_pkg::map_row_t out_row;
	router_pkg::cost_t cost;

	logic [31:0] trace [TRACE_WORDS];
	int rd_idx;
	int errors;
	int timeouts;

	router_top UUT (
		.clk(clk), .rst_n(rst_n),
		.map_valid(map_valid), .net_valid(net_valid),
		.map_row(map_row), .weight_row(weight_row),
		.net_id(net_id), .loc(loc),
		.busy(busy), .out_valid(out_valid),
		.out_row(out_row), .cost(cost)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("FAILED %s: expected %h, actual %h", name, expected, actual);
	endtask

	// ============================================================
	// load maps, send nets and collect the dump of one frame
	// ============================================================
	task automatic run_case(input int case_no);
		int net_cnt;
		int wait_cnt;
		router_pkg::map_row_t exp_row;
		router_pkg::cost_t exp_cost;
		net_cnt = trace[rd_idx];
		rd_idx++;
		for (int r = 0; r < `GRID_DIM; r++) begin
			@(posedge clk);
			map_valid <= 1'b1;
			map_row <= trace[rd_idx];
			weight_row <= trace[rd_idx + 1];
			rd_idx += 2;
		end
		@(posedge clk);
		map_valid <= 1'b0;
		@(negedge clk);
		if (busy !== 1'b0)
			report_mismatch($sformatf("case %0d busy before nets", case_no), 0, busy);
		if (out_valid !== 1'b0)
			report_mismatch($sformatf("case %0d out_valid before nets", case_no), 0, out_valid);
		// new frame starts from zero cost
		if (cost !== '0)
			report_mismatch($sformatf("case %0d cost after load", case_no), 0, cost);

		// source beat, then sink beat
		for (int n = 0; n < net_cnt; n++) begin
			@(posedge clk);
			net_valid <= 1'b1;
			net_id <= trace[rd_idx][`ID_W-1:0];
			loc.x <= trace[rd_idx + 1][`COORD_W-1:0];
			loc.y <= trace[rd_idx + 2][`COORD_W-1:0];
			@(posedge clk);
			loc.x <= trace[rd_idx + 3][`COORD_W-1:0];
			loc.y <= trace[rd_idx + 4][`COORD_W-1:0];
			rd_idx += 5;
			if (n == 0) begin
				@(negedge clk);
				if (busy !== 1'b1)
					report_mismatch($sformatf("case %0d busy after first beat", case_no), 1, busy);
			end
		end
		@(posedge clk);
		net_valid <= 1'b0;

		wait_cnt = 0;
		@(negedge clk);
		while (!out_valid && wait_cnt < WAIT_LIMIT) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (!out_valid) begin
			$display("timeout: case %0d never raised out_valid", case_no);
			timeouts++;
		end else begin
			exp_cost = router_pkg::cost_t'(trace[rd_idx + `GRID_DIM]);
			for (int r = 0; r < `GRID_DIM; r++) begin
				exp_row = trace[rd_idx + r];
				if (out_valid !== 1'b1)
					report_mismatch($sformatf("case %0d out_valid row %0d", case_no, r), 1, out_valid);
				// busy holds until the last row has gone out
				if (busy !== 1'b1)
					report_mismatch($sformatf("case %0d busy row %0d", case_no, r), 1, busy);
				if (out_row !== exp_row)
					report_mismatch($sformatf("case %0d row %0d", case_no, r), exp_row, out_row);
				if (cost !== exp_cost)
					report_mismatch($sformatf("case %0d cost row %0d", case_no, r), exp_cost, cost);
				@(negedge clk);
			end
			// dump is exactly GRID_DIM beats long
			if (out_valid !== 1'b0)
				report_mismatch($sformatf("case %0d out_valid after dump", case_no), 0, out_valid);
			if (busy !== 1'b0)
				report_mismatch($sformatf("case %0d busy after dump", case_no), 0, busy);
		end
		rd_idx += `GRID_DIM + 1;
	endtask

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		int case_total;
		rst_n = 1'b0;
		map_valid = 1'b0;
		net_valid = 1'b0;
		map_row = '0;
		weight_row = '0;
		net_id = '0;
		loc = '0;
		errors = 0;
		timeouts = 0;
		rd_idx = 1;
		for (int i = 0; i < TRACE_WORDS; i++) begin
			trace[i] = '0;
		end
		$readmemh("test/router_trace.txt", trace);
		case_total = trace[0];

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (busy !== 1'b0) report_mismatch("reset busy", 0, busy);
		if (out_valid !== 1'b0) report_mismatch("reset out_valid", 0, out_valid);
		if (cost !== '0) report_mismatch("reset cost", 0, cost);

		if (case_total == 0) begin
			$display("trace file holds no cases");
			errors++;
		end
		for (int c = 1; c <= case_total; c++) begin
			if (timeouts == 0) run_case(c);
		end

		repeat (4) @(posedge clk);
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== logic/router_top.sv ====
`timescale 1ns/1ns
`include "router_config.svh"

module router_top (
	input  logic clk,
	input  logic rst_n,
	input  logic map_valid,
	input  logic net_valid,
	input  router_pkg::map_row_t map_row,
	input  router_pkg::map_row_t weight_row,
	input  router_pkg::net_id_t net_id,
	input  router_pkg::point_t loc,
	output logic busy,
	output logic out_valid,
	output router_pkg::map_row_t out_row,
	output router_pkg::cost_t cost
);

	// ============================================================
	// internal wires
	// ============================================================
	logic pop;
	logic seed;
	logic propagate;
	logic clear;
	logic trace_start;
	logic trace_step;
	logic dump_row_en;
	router_pkg::coord_t dump_row;
	logic net_pending;
	logic sink_reached;
	logic at_source;
	router_pkg::net_t cur_net;
	logic [`GRID_DIM-1:0][`GRID_DIM-1:0] blocked;
	logic [1:0] seq_ptr;
	router_pkg::label_t [3:0] nbr_labels;
	router_pkg::point_t trace_pos;
	logic write_path;
	router_pkg::weight_t step_weight;

	// ============================================================
	// blocks
	// ============================================================
	route_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n),
		.map_valid(map_valid), .net_valid(net_valid),
		.net_pending(net_pending), .sink_reached(sink_reached), .at_source(at_source),
		.pop(pop), .seed(seed), .propagate(propagate), .clear(clear),
		.trace_start(trace_start), .trace_step(trace_step),
		.dump_row_en(dump_row_en), .dump_row(dump_row),
		.busy(busy), .out_valid(out_valid)
	);

	net_queue u_queue (
		.clk(clk), .rst_n(rst_n),
		.net_valid(net_valid), .net_id(net_id), .loc(loc), .pop(pop),
		.cur_net(cur_net), .net_pending(net_pending)
	);

	wave_grid u_wave (
		.clk(clk), .rst_n(rst_n),
		.blocked(blocked), .cur_net(cur_net),
		.seed(seed), .propagate(propagate), .clear(clear),
		.trace_pos(trace_pos), .write_path(write_path),
		.sink_reached(sink_reached), .seq_ptr(seq_ptr), .nbr_labels(nbr_labels)
	);

	path_tracer u_tracer (
		.clk(clk), .rst_n(rst_n),
		.map_valid(map_valid), .cur_net(cur_net),
		.trace_start(trace_start), .trace_step(trace_step),
		.seq_ptr(seq_ptr), .nbr_labels(nbr_labels), .step_weight(step_weight),
		.trace_pos(trace_pos), .write_path(write_path), .at_source(at_source), .cost(cost)
	);

	tile_store u_tiles (
		.clk(clk), .rst_n(rst_n),
		.map_valid(map_valid), .map_row(map_row), .weight_row(weight_row),
		.write_path(write_path), .trace_start(trace_start),
		.trace_pos(trace_pos), .cur_net(cur_net),
		.dump_row_en(dump_row_en), .dump_row(dump_row),
		.out_row(out_row), .step_weight(step_weight), .blocked(blocked)
	);

endmodule

// ==== logic/tile_store.sv ====
`timescale 1ns/1ns
`include "router_config.svh"

module tile_store (
	input  logic clk,
	input  logic rst_n,
	input  logic map_valid,
	input  router_pkg::map_row_t map_row,
	input  router_pkg::map_row_t weight_row,
	input  logic write_path,
	input  logic trace_start,
	input  router_pkg::point_t trace_pos,
	input  router_pkg::net_t cur_net,
	input  logic dump_row_en,
	input  router_pkg::coord_t dump_row,
	output router_pkg::map_row_t out_row,
	output router_pkg::weight_t step_weight,
	output logic [`GRID_DIM-1:0][`GRID_DIM-1:0] blocked
);

	router_pkg::map_row_t loc_map [`GRID_DIM];
	router_pkg::map_row_t wgt_map [`GRID_DIM];
	router_pkg::coord_t load_row;

	// ============================================================
	// row load
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_row <= '0;
		end else if (map_valid) begin
			load_row <= (load_row == router_pkg::coord_t'(`GRID_DIM - 1)) ? '0 : load_row + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (map_valid) begin
			loc_map[load_row] <= map_row;
			wgt_map[load_row] <= weight_row;
		end
		// sink first, then each cell the retrace steps into
		if (trace_start) begin
			loc_map[cur_net.snk.y][cur_net.snk.x*`ID_W +: `ID_W] <= cur_net.id;
		end
		if (write_path) begin
			loc_map[trace_pos.y][trace_pos.x*`ID_W +: `ID_W] <= cur_net.id;
		end
	end

	// ============================================================
	// read side
	// ============================================================
	always_comb begin
		for (int y = 0; y < `GRID_DIM; y++) begin
			for (int x = 0; x < `GRID_DIM; x++) begin
				blocked[y][x] = |loc_map[y][x*`ID_W +: `ID_W];
			end
		end
	end

	assign step_weight = wgt_map[trace_pos.y][trace_pos.x*`ID_W +: `ID_W];
	assign out_row = dump_row_en ? loc_map[dump_row] : '0;

endmodule

// ==== logic/path_tracer.sv ====
`timescale 1ns/1ns

module path_tracer (
	input  logic clk,
	input  logic rst_n,
	input  logic map_valid,
	input  router_pkg::net_t cur_net,
	input  logic trace_start,
	input  logic trace_step,
	input  logic [1:0] seq_ptr,
	input  router_pkg::label_t [3:0] nbr_labels,
	input  router_pkg::weight_t step_weight,
	output router_pkg::point_t trace_pos,
	output logic write_path,
	output logic at_source,
	output router_pkg::cost_t cost
);

	// layer of the cell we are looking for
	logic [1:0] look_cnt;
	router_pkg::label_t want;
	router_pkg::point_t next_pos;

	assign want = look_cnt[1] ? router_pkg::LBL_FRONT_HI : router_pkg::LBL_FRONT_LO;
	assign at_source = (trace_pos == cur_net.src);

	// fixed priority y+1 y-1 x+1 x-1
	always_comb begin
		next_pos = trace_pos;
		if (nbr_labels[0] == want) begin
			next_pos.y = trace_pos.y + 1'b1;
		end else if (nbr_labels[1] == want) begin
			next_pos.y = trace_pos.y - 1'b1;
		end else if (nbr_labels[2] == want) begin
			next_pos.x = trace_pos.x + 1'b1;
		end else begin
			next_pos.x = trace_pos.x - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			trace_pos <= '0;
			look_cnt <= 2'd0;
			write_path <= 1'b0;
		end else begin
			write_path <= trace_step;
			if (trace_start) begin
				trace_pos <= cur_net.snk;
				// wave pointer is one past the sink layer
				look_cnt <= seq_ptr - 2'd2;
			end else if (trace_step) begin
				trace_pos <= next_pos;
				look_cnt <= look_cnt - 2'd1;
			end
		end
	end

	// sink weight is never added
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cost <= '0;
		end else if (map_valid) begin
			cost <= '0;
		end else if (write_path) begin
			cost <= cost + router_pkg::cost_t'(step_weight);
		end
	end

endmodule

// ==== logic/wave_grid.sv ====
`timescale 1ns/1ns
`include "router_config.svh"

module wave_grid (
	input  logic clk,
	input  logic rst_n,
	input  logic [`GRID_DIM-1:0][`GRID_DIM-1:0] blocked,
	input  router_pkg::net_t cur_net,
	input  logic seed,
	input  logic propagate,
	input  logic clear,
	input  router_pkg::point_t trace_pos,
	input  logic write_path,
	output logic sink_reached,
	output logic [1:0] seq_ptr,
	output router_pkg::label_t [3:0] nbr_labels
);

	// indexed [y][x]
	router_pkg::label_t lbl [`GRID_DIM][`GRID_DIM];
	// front rows with an empty row above and below the grid
	logic [`GRID_DIM-1:0] front_pad [`GRID_DIM+2];
	logic [`GRID_DIM-1:0] near_front [`GRID_DIM];
	router_pkg::label_t front_lbl;
	router_pkg::coord_t y_up;
	router_pkg::coord_t y_dn;
	router_pkg::coord_t x_up;
	router_pkg::coord_t x_dn;

	// ============================================================
	// wave neighborhood
	// ============================================================
	always_comb begin
		front_pad[0] = '0;
		front_pad[`GRID_DIM+1] = '0;
		for (int y = 0; y < `GRID_DIM; y++) begin
			for (int x = 0; x < `GRID_DIM; x++) begin
				front_pad[y+1][x] = lbl[y][x][1];
			end
		end
	end

	always_comb begin
		for (int y = 0; y < `GRID_DIM; y++) begin
			near_front[y] = front_pad[y] | front_pad[y+2] |
				(front_pad[y+1] << 1) | (front_pad[y+1] >> 1);
		end
	end

	// layer label follows 0,0,1,1 on the low bit
	assign front_lbl = seq_ptr[1] ? router_pkg::LBL_FRONT_HI : router_pkg::LBL_FRONT_LO;

	// ============================================================
	// label array
	// ============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			seq_ptr <= 2'd0;
			for (int y = 0; y < `GRID_DIM; y++) begin
				for (int x = 0; x < `GRID_DIM; x++) begin
					lbl[y][x] <= router_pkg::LBL_FREE;
				end
			end
		end else if (seed) begin
			for (int y = 0; y < `GRID_DIM; y++) begin
				for (int x = 0; x < `GRID_DIM; x++) begin
					lbl[y][x] <= blocked[y][x] ? router_pkg::LBL_BLOCKED : router_pkg::LBL_FREE;
				end
			end
			// source is layer 0
			lbl[cur_net.src.y][cur_net.src.x] <= router_pkg::LBL_FRONT_LO;
			lbl[cur_net.snk.y][cur_net.snk.x] <= router_pkg::LBL_FREE;
			seq_ptr <= 2'd1;
		end else if (propagate) begin
			for (int y = 0; y < `GRID_DIM; y++) begin
				for (int x = 0; x < `GRID_DIM; x++) begin
					if (lbl[y][x] == router_pkg::LBL_FREE && near_front[y][x])
						lbl[y][x] <= front_lbl;
				end
			end
			seq_ptr <= seq_ptr + 2'd1;
		end else if (clear) begin
			for (int y = 0; y < `GRID_DIM; y++) begin
				for (int x = 0; x < `GRID_DIM; x++) begin
					if (lbl[y][x][1]) lbl[y][x] <= router_pkg::LBL_FREE;
				end
			end
		end else if (write_path) begin
			lbl[trace_pos.y][trace_pos.x] <= router_pkg::LBL_BLOCKED;
		end
	end

	assign sink_reached = lbl[cur_net.snk.y][cur_net.snk.x][1];

	// ============================================================
	// tracer neighbors, y+1 y-1 x+1 x-1
	// ============================================================
	assign y_up = trace_pos.y + 1'b1;
	assign y_dn = trace_pos.y - 1'b1;
	assign x_up = trace_pos.x + 1'b1;
	assign x_dn = trace_pos.x - 1'b1;

	// off-grid reads as free and never matches
	assign nbr_labels[0] = (trace_pos.y != router_pkg::coord_t'(`GRID_DIM - 1)) ?
		lbl[y_up][trace_pos.x] : router_pkg::LBL_FREE;
	assign nbr_labels[1] = (trace_pos.y != '0) ? lbl[y_dn][trace_pos.x] : router_pkg::LBL_FREE;
	assign nbr_labels[2] = (trace_pos.x != router_pkg::coord_t'(`GRID_DIM - 1)) ?
		lbl[trace_pos.y][x_up] : router_pkg::LBL_FREE;
	assign nbr_labels[3] = (trace_pos.x != '0) ? lbl[trace_pos.y][x_dn] : router_pkg::LBL_FREE;

endmodule

// ==== logic/net_queue.sv ====
`timescale 1ns/1ns
`include "router_config.svh"

module net_queue (
	input  logic clk,
	input  logic rst_n,
	input  logic net_valid,
	input  router_pkg::net_id_t net_id,
	input  router_pkg::point_t loc,
	input  logic pop,
	output router_pkg::net_t cur_net,
	output logic net_pending
);

	localparam int PTR_W = $clog2(`MAX_NETS);

	router_pkg::net_t entries [`MAX_NETS];
	// extra msb tells full from empty
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic second_beat;
	router_pkg::net_id_t hold_id;
	router_pkg::point_t hold_src;

	// beat parity and pointers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			second_beat <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (net_valid) second_beat <= !second_beat;
			if (net_valid && second_beat) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// source beat waits here for its sink
	always_ff @(posedge clk) begin
		if (net_valid && !second_beat) begin
			hold_id <= net_id;
			hold_src <= loc;
		end
		if (net_valid && second_beat) begin
			entries[wr_ptr[PTR_W-1:0]] <= {hold_id, hold_src, loc};
		end
	end

	assign cur_net = entries[rd_ptr[PTR_W-1:0]];
	assign net_pending = (wr_ptr != rd_ptr);

endmodule

// ==== logic/route_ctrl.sv ====
`timescale 1ns/1ns
`include "router_config.svh"

module route_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic map_valid,
	input  logic net_valid,
	input  logic net_pending,
	input  logic sink_reached,
	input  logic at_source,
	output logic pop,
	output logic seed,
	output logic propagate,
	output logic clear,
	output logic trace_start,
	output logic trace_step,
	output logic dump_row_en,
	output router_pkg::coord_t dump_row,
	output logic busy,
	output logic out_valid
);

	router_pkg::ctrl_state_t state;
	router_pkg::ctrl_state_t state_nxt;
	logic nets_seen;
	logic dump_last;

	assign dump_last = (dump_row == router_pkg::coord_t'(`GRID_DIM - 1));

	// ============================================================
	// FSM
	// ============================================================
	always_comb begin
		state_nxt = state;
		case (state)
			router_pkg::IDLE: if (map_valid || net_valid) state_nxt = router_pkg::LOAD;
			// nets end on the first quiet cycle
			router_pkg::LOAD: if (nets_seen && !net_valid) state_nxt = router_pkg::SEED;
			router_pkg::SEED: state_nxt = net_pending ? router_pkg::PROPAGATE : router_pkg::DUMP;
			router_pkg::PROPAGATE: if (sink_reached) state_nxt = router_pkg::TRACE_READ;
			router_pkg::TRACE_READ: state_nxt = router_pkg::TRACE_WRITE;
			router_pkg::TRACE_WRITE: state_nxt = at_source ? router_pkg::CLEAR : router_pkg::TRACE_READ;
			router_pkg::CLEAR: state_nxt = router_pkg::SEED;
			router_pkg::DUMP: if (dump_last) state_nxt = router_pkg::IDLE;
			default: state_nxt = router_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= router_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			nets_seen <= 1'b0;
		end else if (state == router_pkg::SEED) begin
			nets_seen <= 1'b0;
		end else if (net_valid) begin
			nets_seen <= 1'b1;
		end
	end

	// ============================================================
	// command pulses
	// ============================================================
	assign seed = (state == router_pkg::SEED) && net_pending;
	assign propagate = (state == router_pkg::PROPAGATE) && !sink_reached;
	// tracer loads the sink on the cycle the wave arrives
	assign trace_start = (state == router_pkg::PROPAGATE) && sink_reached;
	assign trace_step = (state == router_pkg::TRACE_READ);
	assign clear = (state == router_pkg::CLEAR);
	assign pop = (state == router_pkg::CLEAR);

	// ============================================================
	// dump and status
	// ============================================================
	assign out_valid = (state == router_pkg::DUMP);
	assign dump_row_en = (state == router_pkg::DUMP);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dump_row <= '0;
		end else if (state == router_pkg::DUMP) begin
			dump_row <= dump_last ? '0 : dump_row + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else if (state == router_pkg::DUMP && dump_last) begin
			busy <= 1'b0;
		end else if (net_valid) begin
			busy <= 1'b1;
		end
	end

endmodule

// ==== logic/router_pkg.sv ====
`include "router_config.svh"

package router_pkg;

	typedef logic [`COORD_W-1:0] coord_t;
	// zero marks an empty cell
	typedef logic [`ID_W-1:0] net_id_t;
	typedef logic [`ID_W-1:0] weight_t;
	typedef logic [`COST_W-1:0] cost_t;
	typedef logic [1:0] label_t;
	// cell x of a row sits at bits [x*ID_W +: ID_W]
	typedef logic [`GRID_DIM*`ID_W-1:0] map_row_t;

	// wave labels, bit 1 set means the cell is part of the wave
	localparam label_t LBL_FREE = 2'd0;
	localparam label_t LBL_BLOCKED = 2'd1;
	localparam label_t LBL_FRONT_LO = 2'd2;
	localparam label_t LBL_FRONT_HI = 2'd3;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} point_t;

	typedef struct packed {
		net_id_t id;
		point_t src;
		point_t snk;
	} net_t;

	typedef enum logic [2:0] {
		IDLE, LOAD, SEED, PROPAGATE, TRACE_READ, TRACE_WRITE, CLEAR, DUMP
	} ctrl_state_t;

endpackage

// ==== logic/router_config.svh ====
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// grid geometry
`define GRID_DIM 8
`define COORD_W 3

// cell value and net id width
`define ID_W 4

// net queue depth
`define MAX_NETS 8

// accumulated path cost
`define COST_W 14

`endif
